// File: bench/id_checker.sv
`timescale 1ns/1ps
`include "id_settings.svh"

module id_checker import id_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  in_valid_i,
	input  logic                  in_ready_i,
	input  id_req_t               in_req_i,
	input  rf_read_t              rf_read_i,
	input  logic [`ID_WORD_W-1:0] rf_data1_i,
	input  logic [`ID_WORD_W-1:0] rf_data2_i,
	input  wb_fwd_t               ex_fwd_i,
	input  wb_fwd_t               mem_fwd_i,
	input  logic                  out_valid_i,
	input  logic                  out_ready_i,
	input  id_out_t               out_i,
	output int                    mismatch_cnt_o,
	output int                    protocol_cnt_o,
	output int                    pending_o,
	output int                    checked_o
);

	id_out_t exp_q[$]; // predictions in acceptance order
	int      mismatch_cnt = 0;
	int      protocol_cnt = 0;
	int      pending = 0;
	int      checked = 0;
	logic    rst_q;
	logic    stall_q = 1'b0;
	logic    accept_q = 1'b0;
	id_out_t held_q;

	assign mismatch_cnt_o = mismatch_cnt;
	assign protocol_cnt_o = protocol_cnt;
	assign pending_o      = pending;
	assign checked_o      = checked;

	function automatic logic [31:0] pick_operand(input logic en, input logic [4:0] addr,
		input logic [31:0] rf_data, input wb_fwd_t ex, input wb_fwd_t mem,
		input logic [31:0] imm);
		if (!en) begin
			return imm;
		end
		if (ex.wreg && ex.wd == addr) begin
			return ex.wdata; // youngest result first
		end
		if (mem.wreg && mem.wd == addr) begin
			return mem.wdata;
		end
		return rf_data;
	endfunction

	function automatic void predict_bundle(input id_req_t req, input logic [31:0] d1,
		input logic [31:0] d2, input wb_fwd_t ex, input wb_fwd_t mem,
		output id_out_t o, output rf_read_t rd);
		logic [31:0] w;
		logic [5:0]  op;
		logic [5:0]  fn;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  sh;
		logic [15:0] imm16;
		logic [31:0] imm;
		logic [31:0] pc4;
		logic        link;
		br_kind_e    kind;
		w     = req.inst;
		op    = w[31:26];
		rs    = w[25:21];
		rt    = w[20:16];
		sh    = w[10:6];
		fn    = w[5:0];
		imm16 = w[15:0];
		pc4   = req.pc + `ID_PC_STEP;
		imm   = '0;
		link  = 1'b0;
		kind  = br_none;
		o     = '0;
		rd    = '0;
		rd.rd1_addr = rs;
		rd.rd2_addr = rt;
		o.wd        = w[15:11]; // only compared when written
		case (op)
		op_special: begin
			rd.rd1_en = 1'b1;
			rd.rd2_en = 1'b1;
			o.wreg    = 1'b1;
			o.illegal = (sh != 5'd0);
			case (fn)
			fn_and:          o.aluop = alu_and;
			fn_or:           o.aluop = alu_or;
			fn_xor:          o.aluop = alu_xor;
			fn_nor:          o.aluop = alu_nor;
			fn_sll, fn_sllv: o.aluop = alu_sll;
			fn_srl, fn_srlv: o.aluop = alu_srl;
			fn_sra, fn_srav: o.aluop = alu_sra;
			fn_add:          o.aluop = alu_add;
			fn_addu:         o.aluop = alu_addu;
			fn_sub:          o.aluop = alu_sub;
			fn_subu:         o.aluop = alu_subu;
			fn_slt:          o.aluop = alu_slt;
			fn_sltu:         o.aluop = alu_sltu;
			fn_jr:           o.aluop = alu_jr;
			fn_jalr:         o.aluop = alu_jalr;
			default:         o.illegal = 1'b1;
			endcase
			case (fn)
			fn_and, fn_or, fn_xor, fn_nor: o.alusel = sel_logic;
			fn_sllv, fn_srlv, fn_srav:     o.alusel = sel_shift;
			fn_sll, fn_srl, fn_sra: begin
				o.alusel  = sel_shift;
				rd.rd1_en = 1'b0; // shamt goes out as reg1
				imm       = {27'd0, sh};
				o.illegal = (rs != 5'd0);
			end
			fn_jr, fn_jalr: begin
				o.alusel  = sel_jump_branch;
				rd.rd2_en = 1'b0;
				kind      = br_always_reg;
				link      = (fn == fn_jalr);
				o.wreg    = link;
			end
			default: o.alusel = sel_arith;
			endcase
		end
		op_regimm: begin
			o.alusel  = sel_jump_branch;
			rd.rd1_en = 1'b1;
			o.wd      = `ID_LINK_REG;
			link      = rt[4];
			kind      = rt[0] ? br_gez : br_ltz;
			case (rt)
			rt_bltz:   o.aluop = alu_bltz;
			rt_bgez:   o.aluop = alu_bgez;
			rt_bltzal: o.aluop = alu_bltzal;
			rt_bgezal: o.aluop = alu_bgezal;
			default:   o.illegal = 1'b1;
			endcase
			o.wreg = link;
		end
		op_j, op_jal: begin
			o.alusel = sel_jump_branch;
			o.aluop  = (op == op_jal) ? alu_jal : alu_j;
			o.wd     = `ID_LINK_REG;
			link     = (op == op_jal);
			o.wreg   = link;
			kind     = br_always;
		end
		op_beq, op_bne: begin
			o.alusel  = sel_jump_branch;
			rd.rd1_en = 1'b1;
			rd.rd2_en = 1'b1;
			o.aluop   = (op == op_beq) ? alu_beq : alu_bne;
			kind      = (op == op_beq) ? br_eq : br_ne;
		end
		op_blez, op_bgtz: begin
			o.alusel  = sel_jump_branch;
			rd.rd1_en = 1'b1;
			o.aluop   = (op == op_bgtz) ? alu_bgtz : alu_blez;
			kind      = (op == op_bgtz) ? br_gtz : br_lez;
		end
		op_addi, op_addiu, op_slti, op_sltiu: begin
			rd.rd1_en = 1'b1;
			o.wreg    = 1'b1;
			o.wd      = rt;
			o.alusel  = sel_arith;
			imm       = {{16{imm16[15]}}, imm16};
			case (op)
			op_addi:  o.aluop = alu_addi;
			op_addiu: o.aluop = alu_addiu;
			op_slti:  o.aluop = alu_slt;
			default:  o.aluop = alu_sltu;
			endcase
		end
		op_andi, op_ori, op_xori, op_lui: begin
			rd.rd1_en = 1'b1;
			o.wreg    = 1'b1;
			o.wd      = rt;
			o.alusel  = sel_logic;
			imm       = (op == op_lui) ? {imm16, 16'd0} : {16'd0, imm16};
			case (op)
			op_andi: o.aluop = alu_and;
			op_xori: o.aluop = alu_xor;
			default: o.aluop = alu_or; // lui ors the upper half into rs
			endcase
		end
		default: o.illegal = 1'b1;
		endcase

		// illegal words leave as an empty bubble
		if (o.illegal) begin
			rd.rd1_en = 1'b0;
			rd.rd2_en = 1'b0;
			o.aluop   = alu_nop;
			o.alusel  = sel_nop;
			o.wreg    = 1'b0;
			link      = 1'b0;
			kind      = br_none;
			imm       = '0;
		end

		o.reg1 = pick_operand(rd.rd1_en, rs, d1, ex, mem, imm);
		o.reg2 = pick_operand(rd.rd2_en, rt, d2, ex, mem, imm);

		case (kind)
		br_always, br_always_reg: o.branch_flag = 1'b1;
		br_eq:   o.branch_flag = (o.reg1 == o.reg2);
		br_ne:   o.branch_flag = (o.reg1 != o.reg2);
		br_gtz:  o.branch_flag = ($signed(o.reg1) > 0);
		br_lez:  o.branch_flag = ($signed(o.reg1) <= 0);
		br_gez:  o.branch_flag = ($signed(o.reg1) >= 0);
		br_ltz:  o.branch_flag = ($signed(o.reg1) < 0);
		default: o.branch_flag = 1'b0;
		endcase

		if (o.branch_flag) begin
			case (kind)
			br_always:     o.branch_target = {pc4[31:28], w[25:0], 2'b00};
			br_always_reg: o.branch_target = o.reg1;
			default:       o.branch_target = pc4 + ({{16{imm16[15]}}, imm16} << 2);
			endcase
		end
		o.link_addr = link ? req.pc + 2 * `ID_PC_STEP : 32'd0;
	endfunction

	task automatic check_field(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		if (exp !== got) begin
			$display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
			mismatch_cnt++;
		end
	endtask

	task automatic compare_bundle(input id_out_t exp, input id_out_t got);
		check_field("aluop", exp.aluop, got.aluop);
		check_field("alusel", exp.alusel, got.alusel);
		check_field("reg1", exp.reg1, got.reg1);
		check_field("reg2", exp.reg2, got.reg2);
		check_field("wreg", exp.wreg, got.wreg);
		if (exp.wreg) begin
			check_field("wd", exp.wd, got.wd);
		end
		check_field("branch_flag", exp.branch_flag, got.branch_flag);
		check_field("branch_target", exp.branch_target, got.branch_target);
		check_field("link_addr", exp.link_addr, got.link_addr);
		check_field("illegal", exp.illegal, got.illegal);
	endtask

	always @(posedge clk) begin : edge_check
		id_out_t  exp_out;
		id_out_t  new_pred;
		rf_read_t exp_rd;
		rst_q <= rst_n_i;
		if (rst_n_i) begin
			if (stall_q && (out_valid_i !== 1'b1 || out_i !== held_q)) begin
				$display("output bundle changed while execute held it back, time %0t", $time);
				protocol_cnt++;
			end
			if (accept_q && out_valid_i !== 1'b1) begin
				$display("no output one edge after an accepted request, time %0t", $time);
				protocol_cnt++;
			end
			if (out_valid_i && !out_ready_i && in_ready_i) begin
				$display("in_ready_o high while the output is held back, time %0t", $time);
				protocol_cnt++;
			end
			if ((!out_valid_i || out_ready_i) && in_ready_i !== 1'b1) begin
				$display("in_ready_o low with the output register free, time %0t", $time);
				protocol_cnt++;
			end
			if (out_valid_i && out_ready_i) begin // older bundle leaves first
				if (exp_q.size() == 0) begin
					$display("output transfer with no request pending, time %0t", $time);
					protocol_cnt++;
				end else begin
					exp_out = exp_q.pop_front();
					compare_bundle(exp_out, out_i);
					checked++;
				end
			end
			if (in_valid_i && in_ready_i) begin
				predict_bundle(in_req_i, rf_data1_i, rf_data2_i, ex_fwd_i, mem_fwd_i,
					new_pred, exp_rd);
				check_field("rf_read_o", exp_rd, rf_read_i);
				exp_q.push_back(new_pred);
			end
			stall_q  <= out_valid_i && !out_ready_i;
			accept_q <= in_valid_i && in_ready_i;
			held_q   <= out_i;
			pending = exp_q.size();
		end else begin
			stall_q  <= 1'b0;
			accept_q <= 1'b0;
		end
	end

	// reset window and the cycle right after it
	always @(negedge clk) begin
		if ((!rst_n_i || !rst_q) && out_valid_i !== 1'b0) begin
			$display("out_valid_o not low during or right after reset, time %0t", $time);
			protocol_cnt++;
		end
		if (rst_n_i && !rst_q && in_ready_i !== 1'b1) begin
			$display("in_ready_o not high in the first cycle after reset, time %0t", $time);
			protocol_cnt++;
		end
	end

endmodule

// File: bench/tb_id_stage.sv
`timescale 1ns/1ps
`include "id_settings.svh"

module tb_id_stage import id_pkg::*; ();

	localparam int n_tests    = 2000;
	localparam int clk_period = 8;

	// register-type functs for the plain alu mix
	localparam logic [77:0] alu_functs = {fn_and, fn_or, fn_xor, fn_nor, fn_sllv, fn_srlv,
		fn_srav, fn_add, fn_addu, fn_sub, fn_subu, fn_slt, fn_sltu};

	logic                  clk = 1'b0;
	logic                  rst_n_i;
	logic                  in_valid_i;
	logic                  in_ready_o;
	id_req_t               in_req_i;
	rf_read_t              rf_read_o;
	logic [`ID_WORD_W-1:0] rf_data1_i;
	logic [`ID_WORD_W-1:0] rf_data2_i;
	wb_fwd_t               ex_fwd_i;
	wb_fwd_t               mem_fwd_i;
	logic                  out_valid_o;
	logic                  out_ready_i;
	id_out_t               out_o;

	logic [`ID_WORD_W-1:0] rf_table [0:31];
	integer                seed;
	int                    mismatch_cnt;
	int                    protocol_cnt;
	int                    pending_cnt;
	int                    checked_cnt;
	int                    issued;
	int                    sent;
	int                    gap;
	logic                  taken;
	logic [31:0]           word;

	always #(clk_period / 2) clk = ~clk;

	// combinational register file read port
	assign rf_data1_i = rf_table[rf_read_o.rd1_addr];
	assign rf_data2_i = rf_table[rf_read_o.rd2_addr];

	id_stage_top i_id_stage_top (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.in_valid_i  (in_valid_i),
		.in_ready_o  (in_ready_o),
		.in_req_i    (in_req_i),
		.rf_read_o   (rf_read_o),
		.rf_data1_i  (rf_data1_i),
		.rf_data2_i  (rf_data2_i),
		.ex_fwd_i    (ex_fwd_i),
		.mem_fwd_i   (mem_fwd_i),
		.out_valid_o (out_valid_o),
		.out_ready_i (out_ready_i),
		.out_o       (out_o)
	);

	id_checker i_checker (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.in_valid_i     (in_valid_i),
		.in_ready_i     (in_ready_o),
		.in_req_i       (in_req_i),
		.rf_read_i      (rf_read_o),
		.rf_data1_i     (rf_data1_i),
		.rf_data2_i     (rf_data2_i),
		.ex_fwd_i       (ex_fwd_i),
		.mem_fwd_i      (mem_fwd_i),
		.out_valid_i    (out_valid_o),
		.out_ready_i    (out_ready_i),
		.out_i          (out_o),
		.mismatch_cnt_o (mismatch_cnt),
		.protocol_cnt_o (protocol_cnt),
		.pending_o      (pending_cnt),
		.checked_o      (checked_cnt)
	);

	task automatic make_inst(output logic [31:0] w);
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [4:0]  sh;
		logic [15:0] imm16;
		int          pick;
		rs    = 5'($random(seed));
		rt    = 5'($random(seed));
		rd    = 5'($random(seed));
		sh    = 5'($random(seed));
		imm16 = 16'($random(seed));
		w     = $random(seed);
		pick  = {$random(seed)} % 16;
		case (pick)
		0, 1, 2, 3: w = {op_special, rs, rt, rd, 5'd0,
			alu_functs[6 * ({$random(seed)} % 13) +: 6]};
		4: w = {op_special, 5'd0, rt, rd, sh,
			($random(seed) & 1) ? fn_sll : (sh[0] ? fn_srl : fn_sra)};
		5, 6, 7: w = {op_addi + 6'({$random(seed)} % 8), rs, rt, imm16};
		8, 9: w = {op_regimm, rs, 1'($random(seed)), 3'b000, 1'($random(seed)), imm16};
		10: w = {($random(seed) & 1) ? op_jal : op_j, w[25:0]};
		11, 12: begin
			op = op_beq + 6'({$random(seed)} % 4);
			if ({$random(seed)} % 4 == 0) begin
				if (op == op_beq || op == op_bne) begin
					rt = rs; // equal sources
				end else begin
					rs = 5'd0; // zero for blez/bgtz
				end
			end
			w = {op, rs, rt, imm16};
		end
		13: w = {op_special, rs, 5'd0, rd, 5'd0, ($random(seed) & 1) ? fn_jalr : fn_jr};
		14: w = {6'd16 + 6'({$random(seed)} % 48), w[25:0]}; // unused opcodes
		default: w = {($random(seed) & 1) ? op_regimm : op_special, w[25:0]};
		endcase
	endtask

	// forwards often aim at the current sources
	task automatic make_fwd(input logic [4:0] rs, input logic [4:0] rt, output wb_fwd_t f);
		f.wreg = ($random(seed) & 3) != 0;
		case ({$random(seed)} % 3)
		0:       f.wd = rs;
		1:       f.wd = rt;
		default: f.wd = 5'($random(seed));
		endcase
		f.wdata = $random(seed);
	endtask

	initial begin
		seed        = 32'he6d6;
		rst_n_i     = 1'b0;
		in_valid_i  = 1'b0;
		in_req_i    = '0;
		ex_fwd_i    = '0;
		mem_fwd_i   = '0;
		out_ready_i = 1'b0;
		issued      = 0;
		sent        = 0;
		gap         = 0;
		word        = '0;
		rf_table[0] = '0; // $0 reads zero
		for (int r = 1; r < 32; r++) begin
			rf_table[r] = $random(seed);
		end
		repeat (3) @(posedge clk);
		#1 rst_n_i = 1'b1;

		while (sent < n_tests) begin
			@(posedge clk);
			taken = in_valid_i && in_ready_o;
			if (taken) begin
				sent++;
			end
			#1;
			out_ready_i = ({$random(seed)} % 3) != 0;
			if (!in_valid_i || taken) begin
				if (gap == 0 && issued < n_tests) begin
					make_inst(word);
					in_req_i.pc   = $random(seed) & 32'hffff_fffc;
					in_req_i.inst = word;
					in_valid_i    = 1'b1;
					issued++;
					gap = {$random(seed)} % 3;
				end else begin
					in_valid_i = 1'b0;
					if (gap > 0) begin
						gap--;
					end
				end
			end
			make_fwd(word[25:21], word[20:16], ex_fwd_i);
			make_fwd(word[25:21], word[20:16], mem_fwd_i);
		end

		for (int k = 0; k < 100 && pending_cnt != 0; k++) begin
			@(posedge clk);
			#1 out_ready_i = ({$random(seed)} % 3) != 0;
		end
		out_ready_i = 1'b1;
		repeat (3) @(posedge clk); // window for stray outputs

		$display("errors: %0d mismatches, %0d protocol, %0d outputs missing, %0d checked",
			mismatch_cnt, protocol_cnt, pending_cnt, checked_cnt);
		if (mismatch_cnt == 0 && protocol_cnt == 0 && pending_cnt == 0
			&& checked_cnt == n_tests) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		#(n_tests * 4 * clk_period + 200);
		$display("timeout: run did not complete, %0d of %0d requests accepted", sent, n_tests);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: hdl/branch_resolve.sv
`timescale 1ns/1ps
`include "id_settings.svh"

module branch_resolve import id_pkg::*; (
	input  logic [`ID_WORD_W-1:0] pc_i,
	input  dec_ctrl_t             ctrl_i,
	input  logic [`ID_WORD_W-1:0] reg1_i,
	input  logic [`ID_WORD_W-1:0] reg2_i,
	output logic                  branch_flag_o,
	output logic [`ID_WORD_W-1:0] branch_target_o,
	output logic [`ID_WORD_W-1:0] link_addr_o
);

	logic [`ID_WORD_W-1:0] pc_plus_1;
	logic [`ID_WORD_W-1:0] pc_plus_2;
	logic [`ID_WORD_W-1:0] br_offset;
	logic [`ID_WORD_W-1:0] jump_target;
	logic                  reg1_zero;
	logic                  reg1_neg;

	assign pc_plus_1 = pc_i + `ID_WORD_W'(`ID_PC_STEP);
	assign pc_plus_2 = pc_i + `ID_WORD_W'(2 * `ID_PC_STEP); // past the delay slot

	// word offset from imm16, scaled to bytes
	assign br_offset = {{(`ID_WORD_W-`ID_IMM_W-2){ctrl_i.j_index[`ID_IMM_W-1]}},
		ctrl_i.j_index[`ID_IMM_W-1:0], 2'b00};
	assign jump_target = {pc_plus_1[`ID_WORD_W-1 -: `ID_WORD_W-`ID_INDEX_W-2],
		ctrl_i.j_index, 2'b00}; // stays in the current 256 MB region

	assign reg1_zero = (reg1_i == '0);
	assign reg1_neg  = reg1_i[`ID_WORD_W-1];

	always_comb begin
		case (ctrl_i.br_kind)
		br_always, br_always_reg: branch_flag_o = 1'b1;
		br_eq:   branch_flag_o = (reg1_i == reg2_i);
		br_ne:   branch_flag_o = (reg1_i != reg2_i);
		br_gtz:  branch_flag_o = !reg1_neg && !reg1_zero;
		br_lez:  branch_flag_o = reg1_neg || reg1_zero;
		br_gez:  branch_flag_o = !reg1_neg;
		br_ltz:  branch_flag_o = reg1_neg;
		default: branch_flag_o = 1'b0;
		endcase

		if (!branch_flag_o) begin
			branch_target_o = '0;
		end else if (ctrl_i.br_kind == br_always) begin
			branch_target_o = jump_target;
		end else if (ctrl_i.br_kind == br_always_reg) begin
			branch_target_o = reg1_i; // jr, jalr
		end else begin
			branch_target_o = pc_plus_1 + br_offset;
		end
	end

	assign link_addr_o = ctrl_i.is_link ? pc_plus_2 : '0;

endmodule

// File: hdl/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg import id_pkg::*; (
	input  logic    clk,
	input  logic    rst_n_i,

	input  logic    in_valid_i,
	output logic    in_ready_o,
	input  id_out_t in_data_i,

	output logic    out_valid_o,
	input  logic    out_ready_i,
	output id_out_t out_data_o
);

	logic    valid_q;
	id_out_t data_q;
	logic    load;

	// free slot, or the current one leaves this edge
	assign in_ready_o = !valid_q || out_ready_i;
	assign load       = in_valid_i && in_ready_o;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
		end else if (in_ready_o) begin
			valid_q <= in_valid_i; // drains when nothing new comes in
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			data_q <= in_data_i;
		end
	end

	assign out_valid_o = valid_q;
	assign out_data_o  = data_q;

endmodule

// File: hdl/id_pkg.sv
`include "id_settings.svh"

package id_pkg;

	// major opcodes
	localparam logic [`ID_OP_W-1:0] op_special = 6'b000000;
	localparam logic [`ID_OP_W-1:0] op_regimm  = 6'b000001; // branch kind sits in rt
	localparam logic [`ID_OP_W-1:0] op_j       = 6'b000010;
	localparam logic [`ID_OP_W-1:0] op_jal     = 6'b000011;
	localparam logic [`ID_OP_W-1:0] op_beq     = 6'b000100;
	localparam logic [`ID_OP_W-1:0] op_bne     = 6'b000101;
	localparam logic [`ID_OP_W-1:0] op_blez    = 6'b000110;
	localparam logic [`ID_OP_W-1:0] op_bgtz    = 6'b000111;
	localparam logic [`ID_OP_W-1:0] op_addi    = 6'b001000;
	localparam logic [`ID_OP_W-1:0] op_addiu   = 6'b001001;
	localparam logic [`ID_OP_W-1:0] op_slti    = 6'b001010;
	localparam logic [`ID_OP_W-1:0] op_sltiu   = 6'b001011;
	localparam logic [`ID_OP_W-1:0] op_andi    = 6'b001100;
	localparam logic [`ID_OP_W-1:0] op_ori     = 6'b001101;
	localparam logic [`ID_OP_W-1:0] op_xori    = 6'b001110;
	localparam logic [`ID_OP_W-1:0] op_lui     = 6'b001111;

	// special group, funct field
	localparam logic [`ID_FUNCT_W-1:0] fn_sll  = 6'b000000;
	localparam logic [`ID_FUNCT_W-1:0] fn_srl  = 6'b000010;
	localparam logic [`ID_FUNCT_W-1:0] fn_sra  = 6'b000011;
	localparam logic [`ID_FUNCT_W-1:0] fn_sllv = 6'b000100;
	localparam logic [`ID_FUNCT_W-1:0] fn_srlv = 6'b000110;
	localparam logic [`ID_FUNCT_W-1:0] fn_srav = 6'b000111;
	localparam logic [`ID_FUNCT_W-1:0] fn_jr   = 6'b001000;
	localparam logic [`ID_FUNCT_W-1:0] fn_jalr = 6'b001001;
	localparam logic [`ID_FUNCT_W-1:0] fn_add  = 6'b100000;
	localparam logic [`ID_FUNCT_W-1:0] fn_addu = 6'b100001;
	localparam logic [`ID_FUNCT_W-1:0] fn_sub  = 6'b100010;
	localparam logic [`ID_FUNCT_W-1:0] fn_subu = 6'b100011;
	localparam logic [`ID_FUNCT_W-1:0] fn_and  = 6'b100100;
	localparam logic [`ID_FUNCT_W-1:0] fn_or   = 6'b100101;
	localparam logic [`ID_FUNCT_W-1:0] fn_xor  = 6'b100110;
	localparam logic [`ID_FUNCT_W-1:0] fn_nor  = 6'b100111;
	localparam logic [`ID_FUNCT_W-1:0] fn_slt  = 6'b101010;
	localparam logic [`ID_FUNCT_W-1:0] fn_sltu = 6'b101011;

	// regimm group, rt field
	localparam logic [`ID_REG_AW-1:0] rt_bltz   = 5'b00000;
	localparam logic [`ID_REG_AW-1:0] rt_bgez   = 5'b00001;
	localparam logic [`ID_REG_AW-1:0] rt_bltzal = 5'b10000;
	localparam logic [`ID_REG_AW-1:0] rt_bgezal = 5'b10001;

	typedef struct packed {
		logic [`ID_OP_W-1:0]    opcode;
		logic [`ID_REG_AW-1:0]  rs;
		logic [`ID_REG_AW-1:0]  rt;
		logic [`ID_REG_AW-1:0]  rd;
		logic [`ID_SHAMT_W-1:0] shamt;
		logic [`ID_FUNCT_W-1:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [`ID_OP_W-1:0]   opcode;
		logic [`ID_REG_AW-1:0] rs;
		logic [`ID_REG_AW-1:0] rt;
		logic [`ID_IMM_W-1:0]  imm16;
	} i_fmt_t;

	typedef struct packed {
		logic [`ID_OP_W-1:0]    opcode;
		logic [`ID_INDEX_W-1:0] index26;
	} j_fmt_t;

	// one instruction word, three views
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		j_fmt_t j_fmt;
	} inst_word_u;

	// operation handed to execute
	typedef enum logic [4:0] {
		alu_nop, alu_and, alu_or, alu_xor, alu_nor,
		alu_sll, alu_srl, alu_sra,
		alu_add, alu_addu, alu_sub, alu_subu, alu_slt, alu_sltu, alu_addi, alu_addiu,
		alu_j, alu_jal, alu_jr, alu_jalr,
		alu_beq, alu_bne, alu_bgtz, alu_blez, alu_bgez, alu_bltz, alu_bgezal, alu_bltzal
	} alu_op_e;

	// result group in execute
	typedef enum logic [2:0] {
		sel_nop         = 3'b000,
		sel_logic       = 3'b001,
		sel_shift       = 3'b010,
		sel_arith       = 3'b100,
		sel_jump_branch = 3'b110
	} alu_sel_e;

	typedef enum logic [3:0] {
		br_none, br_always, br_always_reg, br_eq, br_ne, br_gtz, br_lez, br_gez, br_ltz
	} br_kind_e;

	typedef struct packed {
		logic [`ID_WORD_W-1:0] pc;
		inst_word_u            inst;
	} id_req_t;

	typedef struct packed {
		logic                  rd1_en;
		logic [`ID_REG_AW-1:0] rd1_addr;
		logic                  rd2_en;
		logic [`ID_REG_AW-1:0] rd2_addr;
	} rf_read_t;

	typedef struct packed {
		logic                  wreg;
		logic [`ID_REG_AW-1:0] wd;
		logic [`ID_WORD_W-1:0] wdata;
	} wb_fwd_t;

	typedef struct packed {
		alu_op_e                aluop;
		alu_sel_e               alusel;
		logic [`ID_REG_AW-1:0]  wd;
		logic                   wreg;
		logic                   is_link;
		br_kind_e               br_kind;
		logic [`ID_INDEX_W-1:0] j_index; // low bits double as branch offset
		logic [`ID_WORD_W-1:0]  imm;
		logic                   illegal;
	} dec_ctrl_t;

	typedef struct packed {
		alu_op_e               aluop;
		alu_sel_e              alusel;
		logic [`ID_WORD_W-1:0] reg1;
		logic [`ID_WORD_W-1:0] reg2;
		logic [`ID_REG_AW-1:0] wd;
		logic                  wreg;
		logic                  branch_flag;
		logic [`ID_WORD_W-1:0] branch_target;
		logic [`ID_WORD_W-1:0] link_addr;
		logic                  illegal;
	} id_out_t;

endpackage

// File: hdl/id_stage_top.sv
`timescale 1ns/1ps
`include "id_settings.svh"

module id_stage_top import id_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n_i,

	// fetch side
	input  logic                  in_valid_i,
	output logic                  in_ready_o,
	input  id_req_t               in_req_i,

	// register file read port, combinational
	output rf_read_t              rf_read_o,
	input  logic [`ID_WORD_W-1:0] rf_data1_i,
	input  logic [`ID_WORD_W-1:0] rf_data2_i,

	// pending results from later stages
	input  wb_fwd_t               ex_fwd_i,
	input  wb_fwd_t               mem_fwd_i,

	// execute side
	output logic                  out_valid_o,
	input  logic                  out_ready_i,
	output id_out_t               out_o
);

	dec_ctrl_t             dec_ctrl;
	logic [`ID_WORD_W-1:0] reg1;
	logic [`ID_WORD_W-1:0] reg2;
	logic                  br_flag;
	logic [`ID_WORD_W-1:0] br_target;
	logic [`ID_WORD_W-1:0] link_addr;
	id_out_t               id_bundle;

	inst_decoder i_decoder (
		.inst_i    (in_req_i.inst),
		.rf_read_o (rf_read_o),
		.ctrl_o    (dec_ctrl)
	);

	operand_select i_sel1 (
		.rd_en_i   (rf_read_o.rd1_en),
		.rd_addr_i (rf_read_o.rd1_addr),
		.rf_data_i (rf_data1_i),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.imm_i     (dec_ctrl.imm),
		.operand_o (reg1)
	);

	operand_select i_sel2 (
		.rd_en_i   (rf_read_o.rd2_en),
		.rd_addr_i (rf_read_o.rd2_addr),
		.rf_data_i (rf_data2_i),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.imm_i     (dec_ctrl.imm),
		.operand_o (reg2)
	);

	branch_resolve i_branch (
		.pc_i            (in_req_i.pc),
		.ctrl_i          (dec_ctrl),
		.reg1_i          (reg1), // forwarded values, so jr sees fresh data
		.reg2_i          (reg2),
		.branch_flag_o   (br_flag),
		.branch_target_o (br_target),
		.link_addr_o     (link_addr)
	);

	always_comb begin
		id_bundle.aluop         = dec_ctrl.aluop;
		id_bundle.alusel        = dec_ctrl.alusel;
		id_bundle.reg1          = reg1;
		id_bundle.reg2          = reg2;
		id_bundle.wd            = dec_ctrl.wd;
		id_bundle.wreg          = dec_ctrl.wreg;
		id_bundle.branch_flag   = br_flag;
		id_bundle.branch_target = br_target;
		id_bundle.link_addr     = link_addr;
		id_bundle.illegal       = dec_ctrl.illegal;
	end

	id_ex_reg i_id_ex_reg (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.in_valid_i  (in_valid_i),
		.in_ready_o  (in_ready_o),
		.in_data_i   (id_bundle),
		.out_valid_o (out_valid_o),
		.out_ready_i (out_ready_i),
		.out_data_o  (out_o)
	);

endmodule

// File: hdl/inst_decoder.sv
`timescale 1ns/1ps
`include "id_settings.svh"

module inst_decoder import id_pkg::*; (
	input  inst_word_u inst_i,
	output rf_read_t   rf_read_o,
	output dec_ctrl_t  ctrl_o
);

	logic [`ID_WORD_W-1:0] imm_sext;
	logic [`ID_WORD_W-1:0] imm_zext;
	logic [`ID_WORD_W-1:0] imm_upper;
	logic [`ID_WORD_W-1:0] imm_shamt;

	assign imm_sext  = {{(`ID_WORD_W-`ID_IMM_W){inst_i.i_fmt.imm16[`ID_IMM_W-1]}},
		inst_i.i_fmt.imm16};
	assign imm_zext  = `ID_WORD_W'(inst_i.i_fmt.imm16);
	assign imm_upper = {inst_i.i_fmt.imm16, {(`ID_WORD_W-`ID_IMM_W){1'b0}}}; // lui
	assign imm_shamt = `ID_WORD_W'(inst_i.r_fmt.shamt);

	always_comb begin
		rf_read_o.rd1_en   = 1'b0;
		rf_read_o.rd1_addr = inst_i.r_fmt.rs;
		rf_read_o.rd2_en   = 1'b0;
		rf_read_o.rd2_addr = inst_i.r_fmt.rt;
		ctrl_o.aluop   = alu_nop;
		ctrl_o.alusel  = sel_nop;
		ctrl_o.wd      = inst_i.r_fmt.rd; // r-type default
		ctrl_o.wreg    = 1'b0;
		ctrl_o.is_link = 1'b0;
		ctrl_o.br_kind = br_none;
		ctrl_o.j_index = inst_i.j_fmt.index26;
		ctrl_o.imm     = '0;
		ctrl_o.illegal = 1'b0;

		case (inst_i.r_fmt.opcode)
		op_special: begin
			rf_read_o.rd1_en = 1'b1;
			rf_read_o.rd2_en = 1'b1;
			ctrl_o.wreg      = 1'b1;
			ctrl_o.illegal   = (inst_i.r_fmt.shamt != '0);
			case (inst_i.r_fmt.funct)
			fn_and:  ctrl_o.aluop = alu_and;
			fn_or:   ctrl_o.aluop = alu_or;
			fn_xor:  ctrl_o.aluop = alu_xor;
			fn_nor:  ctrl_o.aluop = alu_nor;
			fn_sll:  ctrl_o.aluop = alu_sll;
			fn_sllv: ctrl_o.aluop = alu_sll; // same shifter, amount from rs
			fn_srl:  ctrl_o.aluop = alu_srl;
			fn_srlv: ctrl_o.aluop = alu_srl;
			fn_sra:  ctrl_o.aluop = alu_sra;
			fn_srav: ctrl_o.aluop = alu_sra;
			fn_add:  ctrl_o.aluop = alu_add;
			fn_addu: ctrl_o.aluop = alu_addu;
			fn_sub:  ctrl_o.aluop = alu_sub;
			fn_subu: ctrl_o.aluop = alu_subu;
			fn_slt:  ctrl_o.aluop = alu_slt;
			fn_sltu: ctrl_o.aluop = alu_sltu;
			fn_jr:   ctrl_o.aluop = alu_jr;
			fn_jalr: ctrl_o.aluop = alu_jalr;
			default: ctrl_o.illegal = 1'b1;
			endcase
			case (inst_i.r_fmt.funct)
			fn_and, fn_or, fn_xor, fn_nor: ctrl_o.alusel = sel_logic;
			fn_sllv, fn_srlv, fn_srav:     ctrl_o.alusel = sel_shift;
			fn_add, fn_addu, fn_sub, fn_subu, fn_slt, fn_sltu: ctrl_o.alusel = sel_arith;
			fn_sll, fn_srl, fn_sra: begin
				ctrl_o.alusel    = sel_shift;
				rf_read_o.rd1_en = 1'b0; // reg1 carries shamt
				ctrl_o.imm       = imm_shamt;
				ctrl_o.illegal   = (inst_i.r_fmt.rs != '0);
			end
			fn_jr, fn_jalr: begin
				ctrl_o.alusel    = sel_jump_branch;
				rf_read_o.rd2_en = 1'b0;
				ctrl_o.br_kind   = br_always_reg;
				ctrl_o.is_link   = (inst_i.r_fmt.funct == fn_jalr);
				ctrl_o.wreg      = (inst_i.r_fmt.funct == fn_jalr); // jalr links to rd
			end
			default: ;
			endcase
		end

		op_regimm: begin
			ctrl_o.alusel    = sel_jump_branch;
			rf_read_o.rd1_en = 1'b1;
			case (inst_i.i_fmt.rt)
			rt_bltz: begin
				ctrl_o.aluop   = alu_bltz;
				ctrl_o.br_kind = br_ltz;
			end
			rt_bgez: begin
				ctrl_o.aluop   = alu_bgez;
				ctrl_o.br_kind = br_gez;
			end
			rt_bltzal: begin
				ctrl_o.aluop   = alu_bltzal;
				ctrl_o.br_kind = br_ltz;
				ctrl_o.is_link = 1'b1;
			end
			rt_bgezal: begin
				ctrl_o.aluop   = alu_bgezal;
				ctrl_o.br_kind = br_gez;
				ctrl_o.is_link = 1'b1;
			end
			default: ctrl_o.illegal = 1'b1;
			endcase
			ctrl_o.wreg = ctrl_o.is_link; // link written whether taken or not
			ctrl_o.wd   = `ID_REG_AW'(`ID_LINK_REG);
		end

		op_j, op_jal: begin
			ctrl_o.alusel  = sel_jump_branch;
			ctrl_o.br_kind = br_always;
			ctrl_o.is_link = (inst_i.j_fmt.opcode == op_jal);
			ctrl_o.wreg    = ctrl_o.is_link;
			ctrl_o.aluop   = ctrl_o.is_link ? alu_jal : alu_j;
			ctrl_o.wd      = `ID_REG_AW'(`ID_LINK_REG);
		end

		op_beq, op_bne: begin
			ctrl_o.alusel    = sel_jump_branch;
			rf_read_o.rd1_en = 1'b1;
			rf_read_o.rd2_en = 1'b1;
			ctrl_o.aluop     = (inst_i.i_fmt.opcode == op_beq) ? alu_beq : alu_bne;
			ctrl_o.br_kind   = (inst_i.i_fmt.opcode == op_beq) ? br_eq : br_ne;
		end

		op_blez, op_bgtz: begin
			ctrl_o.alusel    = sel_jump_branch;
			rf_read_o.rd1_en = 1'b1; // reg2 gets zero imm
			ctrl_o.aluop     = (inst_i.i_fmt.opcode == op_bgtz) ? alu_bgtz : alu_blez;
			ctrl_o.br_kind   = (inst_i.i_fmt.opcode == op_bgtz) ? br_gtz : br_lez;
		end

		op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui: begin
			rf_read_o.rd1_en = 1'b1; // lui reads rs too, expected $0
			ctrl_o.wreg      = 1'b1;
			ctrl_o.wd        = inst_i.i_fmt.rt;
			case (inst_i.i_fmt.opcode)
			op_addi:  ctrl_o.aluop = alu_addi;
			op_addiu: ctrl_o.aluop = alu_addiu;
			op_slti:  ctrl_o.aluop = alu_slt;
			op_sltiu: ctrl_o.aluop = alu_sltu;
			op_andi:  ctrl_o.aluop = alu_and;
			op_xori:  ctrl_o.aluop = alu_xor;
			default:  ctrl_o.aluop = alu_or; // ori and lui
			endcase
			case (inst_i.i_fmt.opcode)
			op_andi, op_ori, op_xori: begin
				ctrl_o.alusel = sel_logic;
				ctrl_o.imm    = imm_zext;
			end
			op_lui: begin
				ctrl_o.alusel = sel_logic;
				ctrl_o.imm    = imm_upper;
			end
			default: begin
				ctrl_o.alusel = sel_arith;
				ctrl_o.imm    = imm_sext; // sltiu compares against sign extended too
			end
			endcase
		end

		default: ctrl_o.illegal = 1'b1;
		endcase

		// an illegal word turns into a bubble
		if (ctrl_o.illegal) begin
			rf_read_o.rd1_en = 1'b0;
			rf_read_o.rd2_en = 1'b0;
			ctrl_o.aluop     = alu_nop;
			ctrl_o.alusel    = sel_nop;
			ctrl_o.wreg      = 1'b0;
			ctrl_o.is_link   = 1'b0;
			ctrl_o.br_kind   = br_none;
			ctrl_o.imm       = '0;
		end
	end

endmodule

// File: hdl/operand_select.sv
`timescale 1ns/1ps
`include "id_settings.svh"

module operand_select import id_pkg::*; (
	input  logic                  rd_en_i,
	input  logic [`ID_REG_AW-1:0] rd_addr_i,
	input  logic [`ID_WORD_W-1:0] rf_data_i,
	input  wb_fwd_t               ex_fwd_i,
	input  wb_fwd_t               mem_fwd_i,
	input  logic [`ID_WORD_W-1:0] imm_i,
	output logic [`ID_WORD_W-1:0] operand_o
);

	logic ex_hit;
	logic mem_hit;

	// the younger result in ex wins over mem
	assign ex_hit  = rd_en_i && ex_fwd_i.wreg && (ex_fwd_i.wd == rd_addr_i);
	assign mem_hit = rd_en_i && mem_fwd_i.wreg && (mem_fwd_i.wd == rd_addr_i);

	always_comb begin
		if (!rd_en_i) begin
			operand_o = imm_i;
		end else if (ex_hit) begin
			operand_o = ex_fwd_i.wdata;
		end else if (mem_hit) begin
			operand_o = mem_fwd_i.wdata;
		end else begin
			operand_o = rf_data_i;
		end
	end

endmodule

// File: include/id_settings.svh
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// datapath widths
`define ID_WORD_W   32 // data and address word
`define ID_REG_AW   5  // register file address

// instruction field widths
`define ID_OP_W     6
`define ID_FUNCT_W  6
`define ID_SHAMT_W  5
`define ID_IMM_W    16
`define ID_INDEX_W  26 // j/jal index

// return address register for jal, bgezal, bltzal
`define ID_LINK_REG 31

// byte distance between two instructions
// link address is pc plus two of these, one for the delay slot
`define ID_PC_STEP  4

`endif

// File: sources.f
+incdir+include
hdl/id_pkg.sv
hdl/inst_decoder.sv
hdl/operand_select.sv
hdl/branch_resolve.sv
hdl/id_ex_reg.sv
hdl/id_stage_top.sv
bench/id_checker.sv
bench/tb_id_stage.sv
